// ==== fabric_pkg.sv ====
// Shared bus types, address map and completion codes; import into any design file that needs them
package fabric_pkg;

   // ======================================================================
   // Bus types
   // ======================================================================
   typedef logic [15:0] data_t;
   typedef logic [15:0] addr_t;

   // ======================================================================
   // Address map
   // ======================================================================
   localparam addr_t GPIO_BASE    = 16'h0000;
   localparam addr_t EBR_BASE     = 16'h1000;
   localparam int    REGION_WORDS = 256;
   localparam int    OFS_BITS     = $clog2(REGION_WORDS);

   // Word offset inside one region
   typedef logic [OFS_BITS-1:0] ofs_t;

   localparam ofs_t GPIO_SW_OFS  = ofs_t'(0);
   localparam ofs_t GPIO_LED_OFS = ofs_t'(1);

   localparam int LED_WIDTH = 14;
   typedef logic [LED_WIDTH-1:0] led_t;

   // Packet and completion encodings
   localparam int    CMD_WRITE_BIT = 15;
   localparam data_t CPL_HDR_OK    = 16'h4A00;
   localparam data_t CPL_HDR_UR    = 16'h4A01;

   // Receive parser states
   typedef enum logic [1:0] {IDLE, ADDR, DATA} rx_state_e;

endpackage

// ==== req_if.sv ====
// Decoded request channel between the receive parser (src) and the bus stage (dst)
`timescale 1ns/1ns
interface req_if;
   import fabric_pkg::*;

   // valid is a single-cycle strobe, there is no ready
   logic  valid;
   logic  we;
   addr_t addr;
   data_t wdata;

   modport src (
      output valid,
      output we,
      output addr,
      output wdata
   );

   modport dst (
      input valid,
      input we,
      input addr,
      input wdata
   );

endinterface

// ==== core_reset_seq.sv ====
// Stretches the board reset; core_rstn_o releases RST_CYCLES clocks after rstn goes high
`timescale 1ns/1ns
module core_reset_seq #(
   parameter int RST_CYCLES = 128
) (
   input  logic clk_125,
   input  logic rstn,
   output logic core_rstn_o
);

   localparam int CNT_W = $clog2(RST_CYCLES + 1);

   logic [CNT_W-1:0] cnt_q;

   // Counter stops once the core is out of reset
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         cnt_q       <= '0;
         core_rstn_o <= 1'b0;
      end else if (cnt_q == CNT_W'(RST_CYCLES - 1)) begin
         core_rstn_o <= 1'b1;
      end else begin
         cnt_q <= cnt_q + CNT_W'(1);
      end
   end

endmodule

// ==== rx_req_parser.sv ====
// Receive stream parser; turns command/address/data packets into single req_if requests
`timescale 1ns/1ns
module rx_req_parser (
   input  logic              clk_125,
   input  logic              rstn,
   input  fabric_pkg::data_t rx_data_i,
   input  logic              rx_st_i,
   input  logic              rx_end_i,
   req_if.src                req
);
   import fabric_pkg::*;

   rx_state_e state_q;
   logic      issue;

   // Last word of a packet that is being parsed
   assign issue = rx_end_i && (state_q != IDLE);

   // ======================================================================
   // Packet state machine
   // ======================================================================
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         state_q   <= IDLE;
         req.valid <= 1'b0;
      end else begin
         req.valid <= issue;
         if (rx_st_i) begin
            // Command word, always restarts the parse
            state_q <= ADDR;
         end else begin
            case (state_q)
               ADDR: begin
                  state_q <= rx_end_i ? IDLE : DATA;
               end
               DATA: begin
                  if (rx_end_i) begin
                     state_q <= IDLE;
                  end
               end
               default: begin
                  state_q <= IDLE;
               end
            endcase
         end
      end
   end

   // Capture of request fields
   always_ff @(posedge clk_125) begin
      if (rx_st_i) begin
         req.we <= rx_data_i[CMD_WRITE_BIT];
      end
      if (!rx_st_i && state_q == ADDR) begin
         req.addr <= rx_data_i;
      end
      if (!rx_st_i && state_q == DATA) begin
         req.wdata <= rx_data_i;
      end
   end

endmodule

// ==== gpio_regs.sv ====
// GPIO slave; switch read register and LED register with active-low LED output
`timescale 1ns/1ns
module gpio_regs (
   input  logic              clk_125,
   input  logic              rstn,
   input  logic              sel_i,
   input  logic              we_i,
   input  fabric_pkg::ofs_t  ofs_i,
   input  fabric_pkg::data_t wdata_i,
   output fabric_pkg::data_t rdata_o,
   input  logic [7:0]        switch_i,
   output fabric_pkg::led_t  led_o
);
   import fabric_pkg::*;

   led_t led_q;

   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         led_q <= '0;
      end else if (sel_i && we_i && ofs_i == GPIO_LED_OFS) begin
         led_q <= wdata_i[LED_WIDTH-1:0];
      end
   end

   // Registered read, other offsets return zero
   always_ff @(posedge clk_125) begin
      if (sel_i && !we_i) begin
         case (ofs_i)
            GPIO_SW_OFS:  rdata_o <= data_t'(switch_i);
            GPIO_LED_OFS: rdata_o <= data_t'(led_q);
            default:      rdata_o <= '0;
         endcase
      end
   end

   // LEDs light on a low level
   assign led_o = ~led_q;

endmodule

// ==== ebr_ram.sv ====
// Block RAM slave; one region of words, write-through-strobe and one-cycle registered read
`timescale 1ns/1ns
module ebr_ram (
   input  logic              clk_125,
   input  logic              sel_i,
   input  logic              we_i,
   input  fabric_pkg::ofs_t  ofs_i,
   input  fabric_pkg::data_t wdata_i,
   output fabric_pkg::data_t rdata_o
);
   import fabric_pkg::*;

   data_t mem [REGION_WORDS];

   always_ff @(posedge clk_125) begin
      if (sel_i) begin
         if (we_i) begin
            mem[ofs_i] <= wdata_i;
         end else begin
            rdata_o <= mem[ofs_i];
         end
      end
   end

endmodule

// ==== bus_stage.sv ====
// Bus stage; decodes request addresses to the GPIO and RAM slaves and returns read completions
`timescale 1ns/1ns
module bus_stage (
   input  logic              clk_125,
   input  logic              rstn,
   req_if.dst                req,
   input  logic [7:0]        switch_i,
   output fabric_pkg::led_t  led_o,
   output logic              cpl_valid_o,
   output logic              cpl_ur_o,
   output fabric_pkg::data_t cpl_data_o,
   output logic              wr_done_o
);
   import fabric_pkg::*;

   localparam int AW = $bits(addr_t);

   logic  gpio_hit;
   logic  ebr_hit;
   logic  gpio_sel;
   logic  ebr_sel;
   ofs_t  ofs;
   data_t gpio_rdata;
   data_t ebr_rdata;
   logic  rd_v_q;
   logic  rd_miss_q;
   logic  rd_gpio_q;

   // Region decode on the upper address bits
   assign gpio_hit = (req.addr[AW-1:OFS_BITS] == GPIO_BASE[AW-1:OFS_BITS]);
   assign ebr_hit  = (req.addr[AW-1:OFS_BITS] == EBR_BASE[AW-1:OFS_BITS]);
   assign ofs      = req.addr[OFS_BITS-1:0];
   assign gpio_sel = req.valid && gpio_hit;
   assign ebr_sel  = req.valid && ebr_hit;

   gpio_regs u_gpio (
      .clk_125  (clk_125),
      .rstn     (rstn),
      .sel_i    (gpio_sel),
      .we_i     (req.we),
      .ofs_i    (ofs),
      .wdata_i  (req.wdata),
      .rdata_o  (gpio_rdata),
      .switch_i (switch_i),
      .led_o    (led_o)
   );

   ebr_ram u_ebr (
      .clk_125 (clk_125),
      .sel_i   (ebr_sel),
      .we_i    (req.we),
      .ofs_i   (ofs),
      .wdata_i (req.wdata),
      .rdata_o (ebr_rdata)
   );

   // ======================================================================
   // Read pipeline, slave data arrives one cycle after the strobe
   // ======================================================================
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         rd_v_q      <= 1'b0;
         cpl_valid_o <= 1'b0;
         wr_done_o   <= 1'b0;
      end else begin
         rd_v_q      <= req.valid && !req.we;
         cpl_valid_o <= rd_v_q;
         // Writes to unmapped space are dropped but still retire
         wr_done_o   <= req.valid && req.we;
      end
   end

   always_ff @(posedge clk_125) begin
      rd_miss_q <= !(gpio_hit || ebr_hit);
      rd_gpio_q <= gpio_hit;
      cpl_ur_o  <= rd_miss_q;
      if (rd_miss_q) begin
         cpl_data_o <= '0;
      end else if (rd_gpio_q) begin
         cpl_data_o <= gpio_rdata;
      end else begin
         cpl_data_o <= ebr_rdata;
      end
   end

endmodule

// ==== cpl_tx_engine.sv ====
// Completion queue and transmit serializer under link credits; also returns receive credits
`timescale 1ns/1ns
module cpl_tx_engine #(
   parameter int TX_CREDITS = 4,
   parameter int CPL_DEPTH  = 8
) (
   input  logic              clk_125,
   input  logic              rstn,
   input  logic              cpl_valid_i,
   input  logic              cpl_ur_i,
   input  fabric_pkg::data_t cpl_data_i,
   input  logic              wr_done_i,
   output fabric_pkg::data_t tx_data_o,
   output logic              tx_st_o,
   output logic              tx_end_o,
   input  logic              tx_credit_i,
   output logic [1:0]        rx_credit_cnt_o
);
   import fabric_pkg::*;

   localparam int PTR_W  = (CPL_DEPTH > 1) ? $clog2(CPL_DEPTH) : 1;
   localparam int CNT_W  = $clog2(CPL_DEPTH + 1);
   localparam int CRED_W = 16;

   logic              q_ur   [CPL_DEPTH];
   data_t             q_data [CPL_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  q_count;
   logic [CRED_W-1:0] tx_credit_q;
   logic              push;
   logic              cpl_start;
   data_t             data_hold_q;
   logic              wr_cred_q;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(CPL_DEPTH - 1)) ? '0 : p + PTR_W'(1);
   endfunction

   assign push = cpl_valid_i;

   // Header may follow the previous data word back to back
   assign cpl_start = (q_count != '0) && (tx_credit_q != '0) && !tx_st_o;

   // ======================================================================
   // Completion queue
   // ======================================================================
   always_ff @(posedge clk_125) begin
      if (push) begin
         q_ur[wr_ptr_q]   <= cpl_ur_i;
         q_data[wr_ptr_q] <= cpl_data_i;
      end
   end

   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         q_count     <= '0;
         tx_credit_q <= CRED_W'(TX_CREDITS);
         tx_st_o     <= 1'b0;
         tx_end_o    <= 1'b0;
         wr_cred_q   <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (cpl_start) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         q_count     <= q_count + CNT_W'(push) - CNT_W'(cpl_start);
         // One credit per grant cycle, one spent per completion
         tx_credit_q <= tx_credit_q + CRED_W'(tx_credit_i) - CRED_W'(cpl_start);
         tx_st_o     <= cpl_start;
         tx_end_o    <= tx_st_o;
         wr_cred_q   <= wr_done_i;
      end
   end

   // ======================================================================
   // Two-word serializer, header then data
   // ======================================================================
   always_ff @(posedge clk_125) begin
      if (cpl_start) begin
         tx_data_o   <= q_ur[rd_ptr_q] ? CPL_HDR_UR : CPL_HDR_OK;
         data_hold_q <= q_data[rd_ptr_q];
      end else if (tx_st_o) begin
         tx_data_o <= data_hold_q;
      end
   end

   // Write retire plus read data word, up to two credits a cycle
   assign rx_credit_cnt_o = 2'(wr_cred_q) + 2'(tx_end_o);

endmodule

// ==== fabric_top.sv ====
// Packet fabric top level; reset stretcher, receive parser, bus stage and completion transmitter
`timescale 1ns/1ns
module fabric_top #(
   parameter int RST_CYCLES = 128,
   parameter int TX_CREDITS = 4,
   parameter int CPL_DEPTH  = 8
) (
   input  logic                              clk_125,
   input  logic                              rstn,
   input  fabric_pkg::data_t                 rx_data_i,
   input  logic                              rx_st_i,
   input  logic                              rx_end_i,
   output fabric_pkg::data_t                 tx_data_o,
   output logic                              tx_st_o,
   output logic                              tx_end_o,
   input  logic                              tx_credit_i,
   output logic [1:0]                        rx_credit_cnt_o,
   input  logic [7:0]                        switch_i,
   output logic [fabric_pkg::LED_WIDTH-1:0]  led_o
);
   import fabric_pkg::*;

   logic  core_rstn;
   logic  cpl_valid;
   logic  cpl_ur;
   data_t cpl_data;
   logic  wr_done;

   req_if req ();

   core_reset_seq #(
      .RST_CYCLES (RST_CYCLES)
   ) u_rst (
      .clk_125     (clk_125),
      .rstn        (rstn),
      .core_rstn_o (core_rstn)
   );

   // ======================================================================
   // Request pipeline
   // ======================================================================
   rx_req_parser u_parser (
      .clk_125   (clk_125),
      .rstn      (core_rstn),
      .rx_data_i (rx_data_i),
      .rx_st_i   (rx_st_i),
      .rx_end_i  (rx_end_i),
      .req       (req.src)
   );

   bus_stage u_bus (
      .clk_125     (clk_125),
      .rstn        (core_rstn),
      .req         (req.dst),
      .switch_i    (switch_i),
      .led_o       (led_o),
      .cpl_valid_o (cpl_valid),
      .cpl_ur_o    (cpl_ur),
      .cpl_data_o  (cpl_data),
      .wr_done_o   (wr_done)
   );

   cpl_tx_engine #(
      .TX_CREDITS (TX_CREDITS),
      .CPL_DEPTH  (CPL_DEPTH)
   ) u_cpl_tx (
      .clk_125         (clk_125),
      .rstn            (core_rstn),
      .cpl_valid_i     (cpl_valid),
      .cpl_ur_i        (cpl_ur),
      .cpl_data_i      (cpl_data),
      .wr_done_i       (wr_done),
      .tx_data_o       (tx_data_o),
      .tx_st_o         (tx_st_o),
      .tx_end_o        (tx_end_o),
      .tx_credit_i     (tx_credit_i),
      .rx_credit_cnt_o (rx_credit_cnt_o)
   );

endmodule

// ==== fabric_sva.sv ====
// Assertions on completion framing, transmit credits and queue fill; bound into cpl_tx_engine
`timescale 1ns/1ns
module fabric_sva #(
   parameter int CNT_W      = 4,
   parameter int CRED_W     = 16,
   parameter int TX_CREDITS = 4,
   parameter int CPL_DEPTH  = 8
) (
   input logic              clk_125,
   input logic              rstn,
   input logic              push,
   input logic              cpl_start,
   input logic              tx_st_o,
   input logic              tx_end_o,
   input logic              tx_credit_i,
   input logic [CNT_W-1:0]  q_count
);

   logic [CRED_W-1:0] avail_q;
   logic              grant_q;

   // Link credit model built from grants and headers seen at the ports
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         avail_q <= CRED_W'(TX_CREDITS);
         grant_q <= 1'b0;
      end else begin
         avail_q <= avail_q + CRED_W'(grant_q) - CRED_W'(tx_st_o);
         grant_q <= tx_credit_i;
      end
   end

   // Data word directly after the header
   a_end_follows_st: assert property (@(posedge clk_125) disable iff (!rstn)
      tx_st_o |=> tx_end_o)
      else $error("tx_end_o missing one cycle after tx_st_o");

   a_start_with_credit: assert property (@(posedge clk_125) disable iff (!rstn)
      tx_st_o |-> (avail_q != '0))
      else $error("completion started with zero transmit credits");

   a_no_overflow: assert property (@(posedge clk_125) disable iff (!rstn)
      (push && !cpl_start) |-> (q_count < CNT_W'(CPL_DEPTH)))
      else $error("completion queue overflow");

endmodule

bind cpl_tx_engine fabric_sva #(
   .CNT_W      (CNT_W),
   .CRED_W     (CRED_W),
   .TX_CREDITS (TX_CREDITS),
   .CPL_DEPTH  (CPL_DEPTH)
) u_sva (
   .clk_125     (clk_125),
   .rstn        (rstn),
   .push        (push),
   .cpl_start   (cpl_start),
   .tx_st_o     (tx_st_o),
   .tx_end_o    (tx_end_o),
   .tx_credit_i (tx_credit_i),
   .q_count     (q_count)
);

// ==== tb_fabric.sv ====
// Testbench for fabric_top; runs the operations in fabric_vectors.txt and checks completions and LEDs
`timescale 1ns/1ns
module tb_fabric;
   import fabric_pkg::*;

   localparam int RST_CYCLES = 128;
   localparam int TX_CREDITS = 4;
   localparam int CPL_DEPTH  = 8;

   logic                 clk_125;
   logic                 rstn;
   data_t                rx_data_i;
   logic                 rx_st_i;
   logic                 rx_end_i;
   data_t                tx_data_o;
   logic                 tx_st_o;
   logic                 tx_end_o;
   logic                 tx_credit_i;
   logic [1:0]           rx_credit_cnt_o;
   logic [7:0]           switch_i;
   logic [LED_WIDTH-1:0] led_o;

   // Vector table
   byte         op_q[$];
   logic [15:0] addr_q[$];
   logic [15:0] data_q[$];
   logic [15:0] exp_q[$];
   int          n_lines;
   logic        loaded;

   // Completions still owed by the DUT, in request order
   logic [15:0] exp_hdr[$];
   logic [15:0] exp_data[$];
   string       name_q[$];

   int          sent;
   int          returned;
   int          mismatches;
   int          other_errs;
   int          tx_cred;
   logic        grant_seen;
   logic        end_due;
   logic [15:0] cur_data;
   string       cur_name;

   fabric_top #(
      .RST_CYCLES (RST_CYCLES),
      .TX_CREDITS (TX_CREDITS),
      .CPL_DEPTH  (CPL_DEPTH)
   ) fabric_top_i (
      .clk_125         (clk_125),
      .rstn            (rstn),
      .rx_data_i       (rx_data_i),
      .rx_st_i         (rx_st_i),
      .rx_end_i        (rx_end_i),
      .tx_data_o       (tx_data_o),
      .tx_st_o         (tx_st_o),
      .tx_end_o        (tx_end_o),
      .tx_credit_i     (tx_credit_i),
      .rx_credit_cnt_o (rx_credit_cnt_o),
      .switch_i        (switch_i),
      .led_o           (led_o)
   );

   initial begin
      clk_125 = 1'b0;
      forever #20 clk_125 = ~clk_125;
   end

   // ======================================================================
   // Helpers
   // ======================================================================
   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected) begin
         mismatches++;
         $display("mismatch %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   // Header from the address map, unmapped reads get UR
   function automatic logic [15:0] expected_header(input logic [15:0] a);
      int ia;
      ia = int'(a);
      if ((ia >= int'(GPIO_BASE) && ia < int'(GPIO_BASE) + REGION_WORDS) ||
          (ia >= int'(EBR_BASE) && ia < int'(EBR_BASE) + REGION_WORDS)) begin
         return 16'h4A00;
      end
      return 16'h4A01;
   endfunction

   task automatic wait_cycle();
      @(negedge clk_125);
      rx_st_i  = 1'b0;
      rx_end_i = 1'b0;
   endtask

   task automatic send_packet(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
      @(negedge clk_125);
      sent++;
      rx_st_i   = 1'b1;
      rx_end_i  = 1'b0;
      rx_data_i = is_wr ? 16'h8000 : 16'h0000;
      @(negedge clk_125);
      rx_st_i   = 1'b0;
      rx_end_i  = !is_wr;
      rx_data_i = a;
      if (is_wr) begin
         @(negedge clk_125);
         rx_end_i  = 1'b1;
         rx_data_i = d;
      end
   endtask

   task automatic wait_credit();
      while ((sent - returned) >= CPL_DEPTH) begin
         wait_cycle();
      end
   endtask

   task automatic wait_retired(input logic [15:0] a);
      int k;
      for (k = 0; k < 400 && returned != sent; k++) begin
         wait_cycle();
      end
      if (returned != sent) begin
         other_errs++;
         $display("write to %h was never retired by a receive credit", a);
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    n;
      string line;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] e;
      fd = $fopen("fabric_vectors.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
               if (n != 3) begin
                  other_errs++;
                  $display("malformed vector line: %s", line);
               end else begin
                  op_q.push_back(line.getc(0));
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  exp_q.push_back(e);
               end
            end
         end
         $fclose(fd);
      end
      n_lines = op_q.size();
      loaded  = 1'b1;
   endtask

   task automatic apply_reset();
      rstn = 1'b0;
      repeat (3) @(negedge clk_125);
      rstn = 1'b1;
      repeat (2) @(negedge clk_125);
      // Core still held in reset here
      check_value("tx_st_o in reset", 16'h0, 16'(tx_st_o));
      check_value("tx_end_o in reset", 16'h0, 16'(tx_end_o));
      check_value("rx credits in reset", 16'h0, 16'(rx_credit_cnt_o));
      check_value("led_o in reset", 16'h3fff, 16'(led_o));
      repeat (RST_CYCLES + 2) @(negedge clk_125);
      check_value("led_o after reset", 16'h3fff, 16'(led_o));
   endtask

   task automatic run_vectors();
      int i;
      for (i = 0; i < n_lines; i++) begin
         case (op_q[i])
            "S": begin
               wait_cycle();
               switch_i = data_q[i][7:0];
            end
            "R": begin
               wait_credit();
               exp_hdr.push_back(expected_header(addr_q[i]));
               exp_data.push_back(exp_q[i]);
               name_q.push_back($sformatf("vector %0d read %h", i, addr_q[i]));
               send_packet(1'b0, addr_q[i], 16'h0000);
            end
            "W": begin
               wait_credit();
               send_packet(1'b1, addr_q[i], data_q[i]);
               wait_retired(addr_q[i]);
               check_value($sformatf("vector %0d led_o", i), exp_q[i], 16'(led_o));
            end
            default: begin
               other_errs++;
               $display("vector %0d has an unknown operation", i);
            end
         endcase
      end
   endtask

   task automatic drain_and_report();
      int k;
      for (k = 0; k < 2000 && (exp_hdr.size() != 0 || returned != sent); k++) begin
         wait_cycle();
      end
      if (exp_hdr.size() != 0) begin
         other_errs++;
         $display("%0d read completions never arrived", exp_hdr.size());
      end
      repeat (4) wait_cycle();
      check_value("receive credits returned", 16'(sent), 16'(returned));
      $display("%0d requests, %0d mismatches, %0d other errors", sent, mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial begin
      void'($urandom(32'h92ca));
      rstn        = 1'b0;
      rx_data_i   = '0;
      rx_st_i     = 1'b0;
      rx_end_i    = 1'b0;
      tx_credit_i = 1'b0;
      switch_i    = '0;
      sent        = 0;
      returned    = 0;
      mismatches  = 0;
      other_errs  = 0;
      loaded      = 1'b0;
      load_vectors();
      if (n_lines == 0) begin
         other_errs++;
         $display("no vectors could be read from fabric_vectors.txt");
         $display("%0d requests, %0d mismatches, %0d other errors",
                  sent, mismatches, other_errs);
         $display("TB FAILED");
         $finish;
      end else begin
         apply_reset();
         run_vectors();
         drain_and_report();
      end
   end

   // Random transmit credit grants once the core is out of reset
   initial begin
      wait (rstn);
      repeat (RST_CYCLES + 4) @(negedge clk_125);
      forever begin
         @(negedge clk_125);
         tx_credit_i = ($urandom % 6) == 0;
      end
   end

   // Transmit monitor, credit model and receive credit count
   initial begin
      wait (rstn);
      repeat (RST_CYCLES + 2) @(posedge clk_125);
      tx_cred    = TX_CREDITS;
      grant_seen = 1'b0;
      end_due    = 1'b0;
      forever begin
         @(posedge clk_125);
         returned += int'(rx_credit_cnt_o);
         if (tx_end_o !== end_due) begin
            other_errs++;
            $display("framing error, tx_end_o is %b where %b was due", tx_end_o, end_due);
         end else if (end_due) begin
            check_value($sformatf("%s data", cur_name), cur_data, tx_data_o);
         end
         end_due = tx_st_o;
         if (tx_st_o) begin
            if (tx_cred <= 0) begin
               other_errs++;
               $display("a completion started while no transmit credit was left");
            end
            if (exp_hdr.size() == 0) begin
               other_errs++;
               $display("a completion arrived with no read outstanding");
            end else begin
               cur_name = name_q.pop_front();
               cur_data = exp_data.pop_front();
               check_value($sformatf("%s header", cur_name), exp_hdr.pop_front(), tx_data_o);
            end
         end
         tx_cred    = tx_cred + int'(grant_seen) - int'(tx_st_o);
         grant_seen = tx_credit_i;
      end
   end

   // Watchdog
   initial begin
      wait (loaded);
      repeat (n_lines * 40 + RST_CYCLES + 3) @(posedge clk_125);
      other_errs++;
      $display("timeout, the vectors did not complete in time");
      $display("%0d requests, %0d mismatches, %0d other errors", sent, mismatches, other_errs);
      $display("TB FAILED");
      $finish;
   end

endmodule

// ==== fabric_vectors.txt ====
# op addr data expect; op is W write, R read, S set switches (data low byte drives switch_i)
# W expect is led_o after the write retires, R expect is the completion data word
S 0000 00a5 0000
R 0001 0000 0000
R 0000 0000 00a5
W 0001 1234 2dcb
R 0001 0000 1234
W 1000 beef 2dcb
W 1001 0001 2dcb
W 10ff 5a5a 2dcb
W 1080 c3c3 2dcb
R 1000 0000 beef
R 1001 0000 0001
R 10ff 0000 5a5a
R 1080 0000 c3c3
R 2000 0000 0000
W 2001 ffff 2dcb
R 0005 0000 0000
S 0000 003c 0000
R 0000 0000 003c
R 1001 0000 0001
R 0100 0000 0000
R 1100 0000 0000
R 1000 0000 beef
W 0001 ffff 0000
R 0001 0000 3fff
R 1080 0000 c3c3
R 10ff 0000 5a5a

// ==== compile.f ====
fabric_pkg.sv
req_if.sv
core_reset_seq.sv
rx_req_parser.sv
gpio_regs.sv
ebr_ram.sv
bus_stage.sv
cpl_tx_engine.sv
fabric_top.sv
fabric_sva.sv
tb_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fabric -f compile.f

if ./obj_dir/Vtb_fabric | tee /dev/stderr | grep -x "TB PASSED" > /dev/null; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi
